/* verilog/imuldiv_cfg_pkg.sv */
/* sizes shared by the RTL and the testbench
   credit counts must match the requester and consumer buffer sizes */
package imuldiv_cfg_pkg;

  // operand and tag widths
  localparam int xlen = 32;
  localparam int tag_w = 4;

  // request queue depth, also the requester's starting credits
  localparam int req_credits = 2;
  localparam int req_ptr_w = (req_credits > 1) ? $clog2(req_credits) : 1;
  localparam int req_cnt_w = $clog2(req_credits + 1);

  // consumer buffer size, the unit starts with this many response credits
  localparam int resp_credits = 2;
  localparam int resp_cnt_w = $clog2(resp_credits + 1);

  // one bit per iteration in both engines
  localparam int iter_count = 32;
  localparam int iter_w = $clog2(iter_count);

  // engine control sequence, shared by multiplier and divider
  typedef enum logic [1:0] {eng_idle, eng_calc, eng_sign, eng_done} eng_state_e;

endpackage

/* verilog/imuldiv_msg_pkg.sv */
/* request and response message formats
   divide results pack remainder in the upper half, quotient in the lower */
package imuldiv_msg_pkg;

  import imuldiv_cfg_pkg::*;

  // ------------------------------------------------------------------------
  // opcodes
  // ------------------------------------------------------------------------

  typedef enum logic [1:0] {
    op_mul  = 2'd0,  // signed multiply, 64-bit product
    op_div  = 2'd1,  // signed divide
    op_divu = 2'd2   // unsigned divide
  } imuldiv_op_e;

  // ------------------------------------------------------------------------
  // messages
  // ------------------------------------------------------------------------

  // 70 bits
  typedef struct packed {
    imuldiv_op_e      op;
    logic [tag_w-1:0] tag;
    logic [xlen-1:0]  a;
    logic [xlen-1:0]  b;
  } req_msg_t;

  // 68 bits, tag comes back untouched
  typedef struct packed {
    logic [tag_w-1:0]  tag;
    logic [2*xlen-1:0] result;
  } resp_msg_t;

endpackage

/* verilog/imuldiv_req_queue.sv */
/* request buffer of req_credits entries without a full check on enqueue
   the sender must hold a credit for every request it pushes */
`timescale 1ns/10ps

module imuldiv_req_queue
  import imuldiv_cfg_pkg::*;
  import imuldiv_msg_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     enq_valid,
  input  req_msg_t enq_msg,
  output logic     enq_credit,
  output logic     deq_valid,
  output req_msg_t deq_msg,
  input  logic     deq_ready
);

  // payload storage
  req_msg_t mem [req_credits];

  logic [req_ptr_w-1:0] wr_ptr;
  logic [req_ptr_w-1:0] rd_ptr;
  logic [req_cnt_w-1:0] count;
  logic                 deq_fire;

  assign deq_valid = (count != '0);
  assign deq_msg = mem[rd_ptr];
  assign deq_fire = deq_valid && deq_ready;
  // one credit back per entry released
  assign enq_credit = deq_fire;

  always_ff @(posedge clk) begin
    if (enq_valid) begin
      mem[wr_ptr] <= enq_msg;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (enq_valid) begin
        wr_ptr <= (wr_ptr == req_ptr_w'(req_credits - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (deq_fire) begin
        rd_ptr <= (rd_ptr == req_ptr_w'(req_credits - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // occupancy holds when both happen together
      case ({enq_valid, deq_fire})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* verilog/imuldiv_mul_iterative.sv */
/* signed shift-add multiplier, one operation at a time
   result valid iter_count+1 cycles after acceptance, no early exit */
`timescale 1ns/10ps

module imuldiv_mul_iterative
  import imuldiv_cfg_pkg::*;
  import imuldiv_msg_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      req_val,
  output logic      req_rdy,
  input  req_msg_t  req_msg,
  output logic      done_val,
  input  logic      done_rdy,
  output resp_msg_t done_msg
);

  eng_state_e        state;
  logic [iter_w-1:0] count;

  // datapath registers
  logic [2*xlen-1:0] a_reg;
  logic [2*xlen-1:0] acc_reg;
  logic [xlen-1:0]   b_reg;
  logic              sign_a_reg;
  logic              sign_b_reg;
  resp_msg_t         out_reg;

  logic [xlen-1:0] mag_a;
  logic [xlen-1:0] mag_b;
  logic            accept;
  logic            grant;

  // operand magnitudes, most negative maps to itself as unsigned
  assign mag_a = req_msg.a[xlen-1] ? (~req_msg.a + 1'b1) : req_msg.a;
  assign mag_b = req_msg.b[xlen-1] ? (~req_msg.b + 1'b1) : req_msg.b;

  assign req_rdy = (state == eng_idle);
  assign accept = req_val && req_rdy;
  assign done_val = (state == eng_done);
  assign grant = done_val && done_rdy;
  assign done_msg = out_reg;

  // ------------------------------------------------------------------------
  // control
  // ------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= eng_idle;
      count <= '0;
    end else begin
      case (state)
        eng_idle: begin
          if (accept) begin
            state <= eng_calc;
            count <= '0;
          end
        end
        eng_calc: begin
          // last iteration moves on to the sign fix
          if (count == iter_w'(iter_count - 1)) begin
            state <= eng_sign;
          end
          count <= count + 1'b1;
        end
        eng_sign: state <= eng_done;
        // hold the result until the arbiter takes it
        eng_done: begin
          if (grant) begin
            state <= eng_idle;
          end
        end
        default: state <= eng_idle;
      endcase
    end
  end

  // ------------------------------------------------------------------------
  // datapath
  // ------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (accept) begin
      a_reg <= {{xlen{1'b0}}, mag_a};
      b_reg <= mag_b;
      acc_reg <= '0;
      sign_a_reg <= req_msg.a[xlen-1];
      sign_b_reg <= req_msg.b[xlen-1];
      out_reg.tag <= req_msg.tag;
    end else if (state == eng_calc) begin
      // add shifted a when the current b bit is set
      if (b_reg[0]) begin
        acc_reg <= acc_reg + a_reg;
      end
      a_reg <= a_reg << 1;
      b_reg <= b_reg >> 1;
    end else if (state == eng_sign) begin
      // negative product only when exactly one operand was negative
      out_reg.result <= (sign_a_reg ^ sign_b_reg) ? (~acc_reg + 1'b1) : acc_reg;
    end
  end

endmodule

/* verilog/imuldiv_div_iterative.sv */
/* restoring divider for op_div and op_divu, one operation at a time
   divide by zero gives quotient all ones, remainder equal to the dividend */
`timescale 1ns/10ps

module imuldiv_div_iterative
  import imuldiv_cfg_pkg::*;
  import imuldiv_msg_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      req_val,
  output logic      req_rdy,
  input  req_msg_t  req_msg,
  output logic      done_val,
  input  logic      done_rdy,
  output resp_msg_t done_msg
);

  eng_state_e        state;
  logic [iter_w-1:0] count;

  logic [xlen-1:0] rem_reg;
  logic [xlen-1:0] quo_reg;
  logic [xlen-1:0] dsr_reg;
  logic            signed_reg;
  logic            sign_a_reg;
  logic            sign_b_reg;
  logic            zero_reg;
  resp_msg_t       out_reg;

  logic            is_signed;
  logic [xlen-1:0] opa;
  logic [xlen-1:0] opb;
  logic [xlen:0]   shifted;
  logic [xlen+1:0] diff;
  logic            borrow;
  logic [xlen-1:0] quo_fix;
  logic [xlen-1:0] rem_fix;
  logic            accept;
  logic            grant;

  // signed divide works on magnitudes, unsigned on raw operands
  assign is_signed = (req_msg.op == op_div);
  assign opa = (is_signed && req_msg.a[xlen-1]) ? (~req_msg.a + 1'b1) : req_msg.a;
  assign opb = (is_signed && req_msg.b[xlen-1]) ? (~req_msg.b + 1'b1) : req_msg.b;

  // one restoring step, the borrow bit decides
  assign shifted = {rem_reg, quo_reg[xlen-1]};
  assign diff = {1'b0, shifted} - {2'b00, dsr_reg};
  assign borrow = diff[xlen+1];

  // quotient sign is the xor, remainder follows the dividend
  assign quo_fix = zero_reg ? '1 :
                   (signed_reg && (sign_a_reg ^ sign_b_reg)) ? (~quo_reg + 1'b1) : quo_reg;
  assign rem_fix = (signed_reg && sign_a_reg) ? (~rem_reg + 1'b1) : rem_reg;

  assign req_rdy = (state == eng_idle);
  assign accept = req_val && req_rdy;
  assign done_val = (state == eng_done);
  assign grant = done_val && done_rdy;
  assign done_msg = out_reg;

  // ------------------------------------------------------------------------
  // control
  // ------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= eng_idle;
      count <= '0;
    end else begin
      case (state)
        eng_idle: begin
          if (accept) begin
            state <= eng_calc;
            count <= '0;
          end
        end
        eng_calc: begin
          if (count == iter_w'(iter_count - 1)) begin
            state <= eng_sign;
          end
          count <= count + 1'b1;
        end
        eng_sign: state <= eng_done;
        eng_done: begin
          if (grant) begin
            state <= eng_idle;
          end
        end
        default: state <= eng_idle;
      endcase
    end
  end

  // ------------------------------------------------------------------------
  // datapath
  // ------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (accept) begin
      rem_reg <= '0;
      quo_reg <= opa;
      dsr_reg <= opb;
      signed_reg <= is_signed;
      sign_a_reg <= req_msg.a[xlen-1];
      sign_b_reg <= req_msg.b[xlen-1];
      zero_reg <= (req_msg.b == '0);
      out_reg.tag <= req_msg.tag;
    end else if (state == eng_calc) begin
      // keep the difference only when the divisor fits
      rem_reg <= borrow ? shifted[xlen-1:0] : diff[xlen-1:0];
      quo_reg <= {quo_reg[xlen-2:0], ~borrow};
    end else if (state == eng_sign) begin
      out_reg.result <= {rem_fix, quo_fix};
    end
  end

endmodule

/* verilog/imuldiv_resp_arbiter.sv */
/* round-robin grant between the two engines onto one response port
   grants only while a response credit is held; response is registered */
`timescale 1ns/10ps

module imuldiv_resp_arbiter
  import imuldiv_cfg_pkg::*;
  import imuldiv_msg_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      mul_val,
  input  resp_msg_t mul_msg,
  output logic      mul_rdy,
  input  logic      div_val,
  input  resp_msg_t div_msg,
  output logic      div_rdy,
  output logic      resp_valid,
  output resp_msg_t resp_msg,
  input  logic      resp_credit
);

  logic [resp_cnt_w-1:0] credits;
  logic                  has_credit;
  // set means the divider wins a tie
  logic                  prio_div;
  logic                  grant;

  assign has_credit = (credits != '0);
  assign mul_rdy = has_credit && mul_val && !(div_val && prio_div);
  assign div_rdy = has_credit && div_val && !(mul_val && !prio_div);
  assign grant = mul_rdy || div_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      credits <= resp_cnt_w'(resp_credits);
      prio_div <= 1'b0;
      resp_valid <= 1'b0;
    end else begin
      // grant and returned credit in one cycle cancel out
      case ({grant, resp_credit})
        2'b10: credits <= credits - 1'b1;
        2'b01: credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
      if (grant) begin
        prio_div <= ~prio_div;
      end
      resp_valid <= grant;
    end
  end

  // payload only, qualified by resp_valid
  always_ff @(posedge clk) begin
    if (grant) begin
      resp_msg <= div_rdy ? div_msg : mul_msg;
    end
  end

endmodule

/* verilog/imuldiv_unit.sv */
/* iterative multiply/divide unit with credit ports on both sides
   responses may leave out of request order, match them by tag */
`timescale 1ns/10ps

module imuldiv_unit
  import imuldiv_msg_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      req_valid,
  input  req_msg_t  req_msg,
  output logic      req_credit,
  output logic      resp_valid,
  output resp_msg_t resp_msg,
  input  logic      resp_credit
);

  logic      deq_valid;
  req_msg_t  deq_msg;
  logic      deq_ready;
  logic      head_is_mul;

  logic      mul_req_val;
  logic      mul_req_rdy;
  logic      div_req_val;
  logic      div_req_rdy;

  logic      mul_done_val;
  logic      mul_done_rdy;
  resp_msg_t mul_done_msg;
  logic      div_done_val;
  logic      div_done_rdy;
  resp_msg_t div_done_msg;

  // ------------------------------------------------------------------------
  // steer the queue head by opcode
  // ------------------------------------------------------------------------

  assign head_is_mul = (deq_msg.op == op_mul);
  assign mul_req_val = deq_valid && head_is_mul;
  assign div_req_val = deq_valid && !head_is_mul;
  assign deq_ready = head_is_mul ? mul_req_rdy : div_req_rdy;

  imuldiv_req_queue req_queue0 (
    .clk        (clk),
    .reset      (reset),
    .enq_valid  (req_valid),
    .enq_msg    (req_msg),
    .enq_credit (req_credit),
    .deq_valid  (deq_valid),
    .deq_msg    (deq_msg),
    .deq_ready  (deq_ready)
  );

  imuldiv_mul_iterative mul0 (
    .clk      (clk),
    .reset    (reset),
    .req_val  (mul_req_val),
    .req_rdy  (mul_req_rdy),
    .req_msg  (deq_msg),
    .done_val (mul_done_val),
    .done_rdy (mul_done_rdy),
    .done_msg (mul_done_msg)
  );

  imuldiv_div_iterative div0 (
    .clk      (clk),
    .reset    (reset),
    .req_val  (div_req_val),
    .req_rdy  (div_req_rdy),
    .req_msg  (deq_msg),
    .done_val (div_done_val),
    .done_rdy (div_done_rdy),
    .done_msg (div_done_msg)
  );

  // both engines share the one response port
  imuldiv_resp_arbiter arb0 (
    .clk         (clk),
    .reset       (reset),
    .mul_val     (mul_done_val),
    .mul_msg     (mul_done_msg),
    .mul_rdy     (mul_done_rdy),
    .div_val     (div_done_val),
    .div_msg     (div_done_msg),
    .div_rdy     (div_done_rdy),
    .resp_valid  (resp_valid),
    .resp_msg    (resp_msg),
    .resp_credit (resp_credit)
  );

endmodule

/* verification/imuldiv_tb.sv */
/* testbench for imuldiv_unit with requests and expected results from imuldiv_input.txt
   tags in the file must stay unique among requests in flight */
`timescale 1ns/10ps

module imuldiv_tb
  import imuldiv_cfg_pkg::*;
  import imuldiv_msg_pkg::*;
();

  // consumer withholds credits once this many requests have gone out
  localparam int hold_at = 10;
  localparam int hold_cycles = 200;

  logic      clk;
  logic      reset;
  logic      req_valid;
  req_msg_t  req_msg;
  logic      req_credit;
  logic      resp_valid;
  resp_msg_t resp_msg;
  logic      resp_credit;

  // stimulus and expected values with the expected response kept per tag
  req_msg_t          stim_q [$];
  logic [2*xlen-1:0] result_q [$];
  resp_msg_t         exp_resp [2**tag_w];
  int                sent_per_tag [2**tag_w];
  int                got_per_tag [2**tag_w];

  int num_req = 0;
  int limit = 0;
  int cycles = 0;
  int seed;
  int sent = 0;
  int credit_pulses = 0;
  int resp_count = 0;
  int credit_ret = 0;
  logic hold;
  logic timed_out;

  // error counts by kind
  int val_errs = 0;
  int cnt_errs = 0;
  int stim_errs = 0;
  int mon_errs = 0;
  int cons_errs = 0;

  imuldiv_unit dut0 (
    .clk         (clk),
    .reset       (reset),
    .req_valid   (req_valid),
    .req_msg     (req_msg),
    .req_credit  (req_credit),
    .resp_valid  (resp_valid),
    .resp_msg    (resp_msg),
    .resp_credit (resp_credit)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ------------------------------------------------------------------------
  // checks and helpers
  // ------------------------------------------------------------------------

  task automatic check_resp(input resp_msg_t got, input resp_msg_t exp);
    if (got !== exp) begin
      val_errs++;
      $display("ERR %0t resp_msg got tag %h result %h exp tag %h result %h",
               $time, got.tag, got.result, exp.tag, exp.result);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string name);
    if (got != exp) begin
      cnt_errs++;
      $display("ERR %0t %s got %0d exp %0d", $time, name, got, exp);
    end
  endtask

  task automatic finish_run();
    int other;
    other = stim_errs + mon_errs + cons_errs + int'(timed_out);
    $display("errors: value %0d, count %0d, other %0d", val_errs, cnt_errs, other);
    if (val_errs + cnt_errs + other == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  endtask

  // lines that do not parse as five hex fields are comments or blank
  task automatic read_stimulus(output bit ok);
    int                fd;
    int                code;
    string             line;
    logic [1:0]        op;
    logic [xlen-1:0]   a;
    logic [xlen-1:0]   b;
    logic [tag_w-1:0]  tag;
    logic [2*xlen-1:0] res;
    req_msg_t          m;
    fd = $fopen("verification/imuldiv_input.txt", "r");
    ok = (fd != 0);
    if (ok) begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code > 0 && $sscanf(line, "%h %h %h %h %h", op, a, b, tag, res) == 5) begin
          m.op = imuldiv_op_e'(op);
          m.tag = tag;
          m.a = a;
          m.b = b;
          stim_q.push_back(m);
          result_q.push_back(res);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic send_req(input int idx);
    req_msg_t m;
    m = stim_q[idx];
    if (sent_per_tag[m.tag] != got_per_tag[m.tag]) begin
      stim_errs++;
      $display("tag %0d reused while an earlier request still waits", m.tag);
    end
    exp_resp[m.tag].tag = m.tag;
    exp_resp[m.tag].result = result_q[idx];
    sent_per_tag[m.tag]++;
    req_msg = m;
    req_valid = 1'b1;
    sent++;
  endtask

  // ------------------------------------------------------------------------
  // requester
  // ------------------------------------------------------------------------

  initial begin : stimulus
    bit ok;
    int i;
    reset = 1'b1;
    req_valid = 1'b0;
    req_msg = '0;
    read_stimulus(ok);
    if (!ok || stim_q.size() == 0) begin
      stim_errs++;
      $display("could not read any request from verification/imuldiv_input.txt");
      finish_run();
    end else begin
      num_req = stim_q.size();
      limit = num_req * 40 + 200;
      repeat (10) @(posedge clk);
      #1;
      reset = 1'b0;
      i = 0;
      // one request per cycle while a credit is held
      while (i < num_req) begin
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        if (req_credits - sent + credit_pulses > 0) begin
          send_req(i);
          i++;
        end
      end
      @(posedge clk);
      #1;
      req_valid = 1'b0;
      wait (resp_count == num_req && credit_ret == num_req);
      // a few idle cycles to catch stray pulses
      repeat (4) @(posedge clk);
      check_count(credit_pulses, num_req, "req_credit pulses");
      check_count(resp_count, num_req, "resp_valid pulses");
      for (int t = 0; t < 2**tag_w; t++) begin
        check_count(got_per_tag[t], sent_per_tag[t], $sformatf("responses for tag %0d", t));
      end
      finish_run();
    end
  end

  // ------------------------------------------------------------------------
  // output monitor sampling mid-cycle
  // ------------------------------------------------------------------------

  initial begin : monitor
    forever begin
      @(negedge clk);
      if (!reset) begin
        if (sent == 0 && (resp_valid || req_credit)) begin
          mon_errs++;
          $display("output pulse at %0t before the first request", $time);
        end
        if (req_credit) begin
          credit_pulses++;
          if (credit_pulses > sent) begin
            mon_errs++;
            $display("req_credit at %0t with no request outstanding", $time);
          end
        end
        if (resp_valid) begin
          // consumer buffer holds resp_credits responses
          if (resp_count - credit_ret >= resp_credits) begin
            mon_errs++;
            $display("response at %0t sent without a response credit", $time);
          end
          if (sent_per_tag[resp_msg.tag] == got_per_tag[resp_msg.tag]) begin
            mon_errs++;
            $display("response at %0t has unknown tag %0d", $time, resp_msg.tag);
          end else begin
            check_resp(resp_msg, exp_resp[resp_msg.tag]);
          end
          got_per_tag[resp_msg.tag]++;
          resp_count++;
        end
      end
    end
  end

  // ------------------------------------------------------------------------
  // consumer returning credits after a random delay
  // ------------------------------------------------------------------------

  initial begin : consumer
    int  wait_cyc;
    int  hold_left;
    int  hold_from;
    bit  held;
    resp_credit = 1'b0;
    hold = 1'b0;
    seed = 16;
    wait_cyc = 0;
    hold_left = 0;
    hold_from = 0;
    held = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      resp_credit = 1'b0;
      // back-pressure window
      if (!held && sent >= hold_at) begin
        held = 1'b1;
        hold = 1'b1;
        hold_left = hold_cycles;
        hold_from = resp_count;
      end
      if (hold) begin
        hold_left--;
        if (hold_left == 0) begin
          hold = 1'b0;
          if (resp_count - hold_from > resp_credits) begin
            cons_errs++;
            $display("%0d responses arrived while credits were withheld",
                     resp_count - hold_from);
          end
        end
      end else if (wait_cyc > 0) begin
        wait_cyc--;
      end else if (resp_count > credit_ret) begin
        resp_credit = 1'b1;
        credit_ret++;
        wait_cyc = $unsigned($random(seed)) % 4;
      end
    end
  end

  initial begin : watchdog
    timed_out = 1'b0;
    wait (limit > 0);
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    timed_out = 1'b1;
    $display("timeout after %0d cycles with %0d of %0d responses seen",
             cycles, resp_count, num_req);
    finish_run();
  end

endmodule

/* verification/imuldiv_input.txt */
# columns are op a b tag expected, all in hex
# op 0 is mul, 1 is div, 2 is divu and divide results hold remainder then quotient
0 00000003 00000007 0 0000000000000015
1 00000064 00000007 1 000000020000000e
0 fffffffd 00000007 2 ffffffffffffffeb
2 ffffffff 00000010 3 0000000f0fffffff
0 00000000 12345678 4 0000000000000000
1 ffffff9c 00000007 5 fffffffefffffff2
0 80000000 80000000 6 4000000000000000
1 80000000 ffffffff 7 0000000080000000
0 7fffffff 7fffffff 8 3fffffff00000001
1 00001234 00000000 9 00001234ffffffff
0 80000000 7fffffff a c000000080000000
2 80000000 ffffffff b 8000000000000000
0 ffffffff ffffffff c 0000000000000001
1 fffffff9 00000000 d fffffff9ffffffff
0 0000ffff ffff0000 e ffffffff00010000
2 00000000 00000000 f 00000000ffffffff
0 12345678 00000010 0 0000000123456780
1 00000007 fffffffe 1 00000001fffffffd
0 00010000 00010000 2 0000000100000000
2 deadbeef 00010000 3 0000beef0000dead
0 40000000 fffffffc 4 ffffffff00000000
1 80000000 00000002 5 00000000c0000000

/* build.f */
verilog/imuldiv_cfg_pkg.sv
verilog/imuldiv_msg_pkg.sv
verilog/imuldiv_req_queue.sv
verilog/imuldiv_mul_iterative.sv
verilog/imuldiv_div_iterative.sv
verilog/imuldiv_resp_arbiter.sv
verilog/imuldiv_unit.sv
verification/imuldiv_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the imuldiv testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f build.f --top-module imuldiv_tb -o imuldiv_sim
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/imuldiv_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# pass only when the testbench printed its pass line
if grep -q "^TB PASSED$" "$LOG"; then
  exit 0
fi
exit 1
